/* source/link_pkg.sv */
`default_nettype none

package link_pkg;

  typedef logic [7:0] byte_t;

  // ESP command opcodes, numbering kept from the full command set
  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    get_version      = 8'd15,
    set_led          = 8'd26,
    get_config       = 8'd27,
    set_spi_ctrl_reg = 8'd29,
    set_spi_data     = 8'd30,
    get_spi_data     = 8'd31
  } cmd_op_e;

  typedef enum logic [1:0] {
    idle,
    read_bytes
  } parser_state_e;

  localparam int max_params = 3;

  // wide enough to count 0 .. max_params
  typedef logic [$clog2(max_params + 1) - 1:0] param_idx_t;

  // parameter bytes following each opcode
  localparam param_idx_t n_params_get_cookie       = 2'd0;
  localparam param_idx_t n_params_get_version      = 2'd0;
  localparam param_idx_t n_params_set_led          = 2'd1;
  localparam param_idx_t n_params_get_config       = 2'd0;
  localparam param_idx_t n_params_set_spi_ctrl_reg = 2'd1;
  localparam param_idx_t n_params_set_spi_data     = 2'd1;
  localparam param_idx_t n_params_get_spi_data     = 2'd0;

  localparam byte_t cookie = 8'hAF;

  localparam logic [2:0] version_major = 3'd0;
  localparam logic [4:0] version_minor = 5'd3;

  // flash sck timing in clk cycles
  localparam int flash_bit_period  = 16;
  localparam int flash_half_period = flash_bit_period / 2;
  localparam int flash_phase_bits  = $clog2(flash_bit_period);
  localparam int flash_xfer_cycles = 8 * flash_bit_period;
  localparam int flash_cnt_bits    = $clog2(flash_xfer_cycles);

endpackage

`default_nettype wire

/* source/cmd_if.sv */
`default_nettype none

interface cmd_if;
  import link_pkg::*;

  // one-cycle strobes
  logic    action;
  logic    bad_op;
  // valid while action is high
  cmd_op_e op;
  byte_t   param;

  modport parser (
    output action, op, param, bad_op
  );

  modport regs (
    input action, op, param, bad_op
  );

endinterface

`default_nettype wire

/* source/flash_xfer_if.sv */
`default_nettype none

interface flash_xfer_if;
  import link_pkg::*;

  // four-phase handshake, req/ack both return to zero
  logic  req;
  logic  ack;
  byte_t wdata;
  byte_t rdata;

  modport ctrl (
    output req, wdata,
    input  ack, rdata
  );

  modport master (
    input  req, wdata,
    output ack, rdata
  );

endinterface

`default_nettype wire

/* source/esp_spi_slave.sv */
`default_nettype none

module esp_spi_slave (
  input  logic           clk,
  input  logic           cass_out_sel_n,
  input  logic           cs_fpga,
  input  logic           sck,
  input  logic           mosi,
  input  link_pkg::byte_t resp_byte,
  output link_pkg::byte_t byte_in,
  output logic           byte_valid,
  output logic           miso
);
  import link_pkg::*;

  logic [2:0] sck_r;
  logic [2:0] cs_r;
  logic [1:0] mosi_r;
  logic [2:0] bit_cnt;
  logic       valid_q;
  byte_t      rx_q;
  byte_t      tx_q;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;

  assign sck_rise  = (sck_r[2:1] == 2'b01);
  assign sck_fall  = (sck_r[2:1] == 2'b10);
  assign cs_active = ~cs_r[2];

  // input synchronizers with cs idling high
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_r  <= 3'b000;
      cs_r   <= 3'b111;
      mosi_r <= 2'b00;
    end else begin
      sck_r  <= {sck_r[1:0], sck};
      cs_r   <= {cs_r[1:0], cs_fpga};
      mosi_r <= {mosi_r[0], mosi};
    end
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bit_cnt <= 3'd0;
      valid_q <= 1'b0;
      tx_q    <= '0;
    end else begin
      valid_q <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= 3'd0;
      end else begin
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7)
            valid_q <= 1'b1;
        end
        // response captured after the first bit, then shifted msb first
        if (sck_fall) begin
          if (bit_cnt == 3'd1)
            tx_q <= resp_byte;
          else
            tx_q <= {tx_q[6:0], 1'b0};
        end
      end
    end
  end

  // receive shift register
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise)
      rx_q <= {rx_q[6:0], mosi_r[1]};
  end

  assign byte_in    = rx_q;
  assign byte_valid = valid_q;
  assign miso       = cs_active ? tx_q[7] : 1'bz;

endmodule

`default_nettype wire

/* source/cmd_parser.sv */
`default_nettype none

module cmd_parser (
  input  logic            clk,
  input  logic            cass_out_sel_n,
  input  link_pkg::byte_t byte_in,
  input  logic            byte_valid,
  cmd_if.parser           cmd
);
  import link_pkg::*;

  parser_state_e state;
  param_idx_t    to_read;
  param_idx_t    op_params;
  logic          op_known;
  logic          action_q;
  logic          bad_op_q;
  cmd_op_e       op_q;
  byte_t         param_q;

  // parameter count lookup for the incoming opcode
  always_comb begin
    op_known  = 1'b1;
    op_params = '0;
    case (byte_in)
      get_cookie:       op_params = n_params_get_cookie;
      get_version:      op_params = n_params_get_version;
      set_led:          op_params = n_params_set_led;
      get_config:       op_params = n_params_get_config;
      set_spi_ctrl_reg: op_params = n_params_set_spi_ctrl_reg;
      set_spi_data:     op_params = n_params_set_spi_data;
      get_spi_data:     op_params = n_params_get_spi_data;
      default:          op_known  = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state    <= idle;
      to_read  <= '0;
      action_q <= 1'b0;
      bad_op_q <= 1'b0;
    end else begin
      action_q <= 1'b0;
      bad_op_q <= 1'b0;
      if (byte_valid) begin
        case (state)
          idle: begin
            if (!op_known) begin
              bad_op_q <= 1'b1;
            end else if (op_params == '0) begin
              action_q <= 1'b1;
            end else begin
              to_read <= op_params;
              state   <= read_bytes;
            end
          end
          read_bytes: begin
            // strobe on the last parameter byte
            if (to_read == param_idx_t'(1)) begin
              action_q <= 1'b1;
              state    <= idle;
            end else begin
              to_read <= to_read - param_idx_t'(1);
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

  // opcode and parameter hold registers
  always_ff @(posedge clk) begin
    if (byte_valid) begin
      if (state == idle)
        op_q <= cmd_op_e'(byte_in);
      else
        param_q <= byte_in;
    end
  end

  assign cmd.action = action_q;
  assign cmd.bad_op = bad_op_q;
  assign cmd.op     = op_q;
  assign cmd.param  = param_q;

endmodule

`default_nettype wire

/* source/ctrl_regs.sv */
`default_nettype none

module ctrl_regs (
  input  logic            clk,
  input  logic            cass_out_sel_n,
  input  logic [3:0]      conf,
  cmd_if.regs             cmd,
  flash_xfer_if.ctrl      fx,
  output link_pkg::byte_t resp_byte,
  output logic [3:0]      led,
  output logic            led_red,
  output logic            led_green,
  output logic            led_blue,
  output logic            flash_spi_cs_n
);
  import link_pkg::*;

  // bit 7 selects the flash
  byte_t spi_ctrl;
  byte_t resp_q;
  byte_t wdata_q;
  byte_t rdata_q;
  logic  req_q;
  logic  err_q;
  logic  busy;

  assign busy = fx.req | fx.ack;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      led_red   <= 1'b0;
      led_green <= 1'b0;
      led_blue  <= 1'b0;
      spi_ctrl  <= '0;
      resp_q    <= '0;
      err_q     <= 1'b0;
    end else begin
      if (cmd.action) begin
        case (cmd.op)
          set_led: begin
            led_red   <= cmd.param[0];
            led_green <= cmd.param[1];
            led_blue  <= cmd.param[2];
          end
          set_spi_ctrl_reg: spi_ctrl <= cmd.param;
          get_cookie:       resp_q   <= cookie;
          get_version:      resp_q   <= {version_major, version_minor};
          get_config:       resp_q   <= {4'b0000, ~conf};
          get_spi_data:     resp_q   <= rdata_q;
          default: ;
        endcase
      end
      // sticky until reset
      if (cmd.bad_op)
        err_q <= 1'b1;
    end
  end

  // flash transfer request, dropped when a transfer is still running
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      req_q <= 1'b0;
    end else if (req_q && fx.ack) begin
      req_q <= 1'b0;
    end else if (cmd.action && cmd.op == set_spi_data && !busy) begin
      req_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd.action && cmd.op == set_spi_data && !busy)
      wdata_q <= cmd.param;
    if (req_q && fx.ack)
      rdata_q <= fx.rdata;
  end

  assign fx.req         = req_q;
  assign fx.wdata       = wdata_q;
  assign resp_byte      = resp_q;
  assign flash_spi_cs_n = ~spi_ctrl[7];
  assign led            = {err_q, 2'b00, busy};

endmodule

`default_nettype wire

/* source/flash_spi_master.sv */
`default_nettype none

module flash_spi_master (
  input  logic         clk,
  input  logic         cass_out_sel_n,
  flash_xfer_if.master fx,
  input  logic         flash_spi_so,
  output logic         flash_spi_clk,
  output logic         flash_spi_si
);
  import link_pkg::*;

  logic [flash_cnt_bits-1:0]   cnt;
  logic [flash_phase_bits-1:0] phase;
  logic                        run;
  logic                        ack_q;
  logic                        si_q;
  byte_t                       shift_q;

  assign phase = cnt[flash_phase_bits-1:0];

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      run     <= 1'b0;
      cnt     <= '0;
      ack_q   <= 1'b0;
      si_q    <= 1'b0;
      shift_q <= '0;
    end else if (run) begin
      cnt <= cnt + 1'b1;
      // low half start drives the next bit, high half start samples
      if (phase == '0)
        si_q <= shift_q[7];
      else if (phase == flash_phase_bits'(flash_half_period))
        shift_q <= {shift_q[6:0], flash_spi_so};
      if (cnt == flash_cnt_bits'(flash_xfer_cycles - 1)) begin
        run   <= 1'b0;
        ack_q <= 1'b1;
      end
    end else if (ack_q) begin
      // hold ack until the requester lets go
      if (!fx.req)
        ack_q <= 1'b0;
    end else if (fx.req) begin
      run     <= 1'b1;
      cnt     <= '0;
      shift_q <= fx.wdata;
    end
  end

  assign flash_spi_clk = run & phase[flash_phase_bits-1];
  assign flash_spi_si  = si_q;
  assign fx.ack        = ack_q;
  assign fx.rdata      = shift_q;

endmodule

`default_nettype wire

/* source/esp_bridge_top.sv */
`default_nettype none

module esp_bridge_top (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic       cs_fpga,
  input  logic       sck,
  input  logic       mosi,
  input  logic [3:0] conf,
  input  logic       flash_spi_so,
  output logic       miso,
  output logic [3:0] led,
  output logic       led_red,
  output logic       led_green,
  output logic       led_blue,
  output logic       flash_spi_cs_n,
  output logic       flash_spi_clk,
  output logic       flash_spi_si
);
  import link_pkg::*;

  byte_t byte_in;
  byte_t resp_byte;
  logic  byte_valid;

  cmd_if        cmd ();
  flash_xfer_if fx ();

  esp_spi_slave esp_spi_slave_inst (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cs_fpga        (cs_fpga),
    .sck            (sck),
    .mosi           (mosi),
    .resp_byte      (resp_byte),
    .byte_in        (byte_in),
    .byte_valid     (byte_valid),
    .miso           (miso)
  );

  cmd_parser cmd_parser_inst (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .byte_in        (byte_in),
    .byte_valid     (byte_valid),
    .cmd            (cmd.parser)
  );

  ctrl_regs ctrl_regs_inst (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .conf           (conf),
    .cmd            (cmd.regs),
    .fx             (fx.ctrl),
    .resp_byte      (resp_byte),
    .led            (led),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .flash_spi_cs_n (flash_spi_cs_n)
  );

  flash_spi_master flash_spi_master_inst (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .fx             (fx.master),
    .flash_spi_so   (flash_spi_so),
    .flash_spi_clk  (flash_spi_clk),
    .flash_spi_si   (flash_spi_si)
  );

endmodule

`default_nettype wire

/* verification/link_checker.sv */
`default_nettype none

module link_checker (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic       cs_fpga,
  input  logic       sck,
  input  logic       miso,
  input  logic [3:0] led,
  input  logic       led_red,
  input  logic       led_green,
  input  logic       led_blue,
  input  logic       flash_spi_cs_n,
  input  logic       flash_spi_clk,
  output logic [3:0] bits_seen
);

  localparam int sck_per_byte = 8;

  logic [2:0] sck_r;
  logic [2:0] cs_r;
  logic [7:0] rx;
  logic       fclk_q     = 1'b0;
  logic       busy_q     = 1'b0;
  int         fclk_rises = 0;
  int         errors     = 0;

  // three-stage sync like the slave so samples land mid-bit
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_r     <= 3'b000;
      cs_r      <= 3'b111;
      rx        <= '0;
      bits_seen <= '0;
    end else begin
      sck_r <= {sck_r[1:0], sck};
      cs_r  <= {cs_r[1:0], cs_fpga};
      if (cs_r[2]) begin
        bits_seen <= '0;
      end else if (sck_r[2:1] == 2'b01 && bits_seen != 4'd8) begin
        rx        <= {rx[6:0], miso};
        bits_seen <= bits_seen + 4'd1;
      end
    end
  end

  // one flash sck pulse per data bit while led[0] marks a transfer
  always @(negedge clk) begin
    if (cass_out_sel_n) begin
      if (led[0] && !busy_q)
        fclk_rises = 0;
      else if (flash_spi_clk && !fclk_q)
        fclk_rises++;
      if (busy_q && !led[0] && fclk_rises != sck_per_byte) begin
        errors++;
        $display("** Error flash_sck_rises: expected %0d, actual %0d",
                 sck_per_byte, fclk_rises);
      end
    end
    fclk_q = flash_spi_clk;
    busy_q = led[0];
  end

  // response starts at rise 2 and its last bit appears after the final sck fall
  task automatic check_byte(input string name, input logic [7:0] expected);
    logic [7:0] actual;
    actual = {rx[6:0], miso};
    if (actual !== expected) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_leds(input string name, input logic [3:0] exp_led,
                            input logic [2:0] exp_rgb, input logic exp_cs_n);
    if ({led, led_red, led_green, led_blue, flash_spi_cs_n} !== {exp_led, exp_rgb, exp_cs_n}) begin
      errors++;
      $display("** Error %s: expected led=%h rgb=%b cs_n=%b, actual led=%h rgb=%b cs_n=%b",
               name, exp_led, exp_rgb, exp_cs_n, led, {led_red, led_green, led_blue},
               flash_spi_cs_n);
    end
  endtask

endmodule

`default_nettype wire

/* verification/esp_bridge_asserts.sv */
`default_nettype none

module esp_bridge_asserts (
  input logic clk,
  input logic cass_out_sel_n,
  input logic req,
  input logic ack
);

  // requester keeps req up until the byte is back
  req_held_until_ack: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    req && !ack |=> req)
    else $error("flash req dropped before ack");

  ack_needs_req: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    $rose(ack) |-> req)
    else $error("flash ack rose with no req");

  ack_held_until_req_low: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    ack && req |=> ack)
    else $error("flash ack dropped while req still high");

endmodule

bind flash_spi_master esp_bridge_asserts esp_bridge_asserts_inst (
  .clk            (clk),
  .cass_out_sel_n (cass_out_sel_n),
  .req            (fx.req),
  .ack            (fx.ack)
);

`default_nettype wire

/* verification/tb_esp_bridge.sv */
`default_nettype none

module tb_esp_bridge;

  localparam int sck_half   = 20;
  localparam int cs_gap     = 20;
  localparam int bit_limit  = 200;
  localparam int idle_limit = 1000;

  logic       clk;
  logic       cass_out_sel_n;
  logic       cs_fpga;
  logic       sck;
  logic       mosi;
  logic [3:0] conf;
  wire        flash_spi_so;
  wire        miso;
  logic [3:0] led;
  logic       led_red;
  logic       led_green;
  logic       led_blue;
  logic       flash_spi_cs_n;
  logic       flash_spi_clk;
  logic       flash_spi_si;
  logic [3:0] bits_seen;
  int         timeouts;
  int         bad_lines;
  int         fd;
  int         got;
  string      line;

  // flash loopback so a transfer reads back the byte it wrote
  assign flash_spi_so = flash_spi_si;

  esp_bridge_top esp_bridge_top_inst (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cs_fpga        (cs_fpga),
    .sck            (sck),
    .mosi           (mosi),
    .conf           (conf),
    .flash_spi_so   (flash_spi_so),
    .miso           (miso),
    .led            (led),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .flash_spi_cs_n (flash_spi_cs_n),
    .flash_spi_clk  (flash_spi_clk),
    .flash_spi_si   (flash_spi_si)
  );

  link_checker link_checker_inst (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cs_fpga        (cs_fpga),
    .sck            (sck),
    .miso           (miso),
    .led            (led),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .flash_spi_cs_n (flash_spi_cs_n),
    .flash_spi_clk  (flash_spi_clk),
    .bits_seen      (bits_seen)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // one spi byte under cs sent msb first with sck idling low
  task automatic exchange_byte(input logic [7:0] tx, input logic [7:0] expected,
                               input logic check, input string name);
    int cycles;
    cs_fpga = 1'b0;
    repeat (sck_half) @(negedge clk);
    for (int i = 7; i >= 0; i--) begin
      mosi = tx[i];
      repeat (sck_half) @(negedge clk);
      sck = 1'b1;
      repeat (sck_half) @(negedge clk);
      sck = 1'b0;
    end
    repeat (sck_half) @(negedge clk);
    cycles = 0;
    while (bits_seen != 4'd8 && cycles < bit_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (bits_seen != 4'd8) begin
      $display("timeout: checker saw only %0d sck rises during %s", bits_seen, name);
      timeouts++;
    end else if (check) begin
      link_checker_inst.check_byte(name, expected);
    end
    cs_fpga = 1'b1;
    repeat (cs_gap) @(negedge clk);
  endtask

  // led bit 0 shows a flash transfer in flight
  task automatic wait_flash_idle(input string name);
    int cycles;
    cycles = 0;
    while (led[0] !== 1'b0 && cycles < idle_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (led[0] !== 1'b0) begin
      $display("timeout: flash transfer still busy after %0d cycles before %s",
               idle_limit, name);
      timeouts++;
    end
  endtask

  task automatic run_line(input string text);
    string      kind;
    string      name;
    logic [7:0] tx;
    logic [7:0] rx_exp;
    int         flag;
    logic [3:0] led_exp;
    logic [2:0] rgb_exp;
    logic       cs_n_exp;
    int         n;
    n = $sscanf(text, "%s", kind);
    if (n < 1 || kind == "#")
      return;
    if (kind == "B") begin
      n = $sscanf(text, "%s %h %h %d %s", kind, tx, rx_exp, flag, name);
      if (n == 5) begin
        exchange_byte(tx, rx_exp, flag != 0, name);
        return;
      end
    end else if (kind == "L") begin
      n = $sscanf(text, "%s %h %b %b %s", kind, led_exp, rgb_exp, cs_n_exp, name);
      if (n == 5) begin
        wait_flash_idle(name);
        link_checker_inst.check_leds(name, led_exp, rgb_exp, cs_n_exp);
        return;
      end
    end
    $display("test data line could not be read, it starts with %s", kind);
    bad_lines++;
  endtask

  initial begin
    cass_out_sel_n = 1'b0;
    cs_fpga        = 1'b1;
    sck            = 1'b0;
    mosi           = 1'b0;
    conf           = 4'b0101;
    timeouts       = 0;
    bad_lines      = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    cass_out_sel_n = 1'b1;
    repeat (5) @(negedge clk);
    fd = $fopen("verification/bridge_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open verification/bridge_testdata.txt");
      bad_lines++;
    end else begin
      while (!$feof(fd)) begin
        got = $fgets(line, fd);
        if (got > 0)
          run_line(line);
      end
      $fclose(fd);
    end
    $display("errors: %0d mismatches, %0d timeouts, %0d data file problems",
             link_checker_inst.errors, timeouts, bad_lines);
    if (link_checker_inst.errors == 0 && timeouts == 0 && bad_lines == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/bridge_testdata.txt */
# B <mosi hex> <expected miso hex> <check 0 or 1> <name>, one spi byte, a read answers on the next byte
# L <led hex> <red green blue bits> <flash cs_n> <name>, compared once the flash is idle
B 00 00 0 get_cookie
B 0F AF 1 cookie
B 1B 03 1 version
B 00 0A 1 config
B 1A AF 1 cookie_again
B 05 AF 1 led_param_05
L 0 101 1 led_05
B 1A AF 0 set_led_02
B 02 AF 0 led_param_02
L 0 010 1 led_02
B 1D AF 0 spi_ctrl_sel
B 80 AF 0 ctrl_param_80
L 0 010 0 flash_selected
B 1E AF 0 spi_data_3c
B 3C AF 0 data_param_3c
L 0 010 0 xfer_3c_done
B 1F AF 0 get_spi_data_3c
B 00 3C 1 spi_data_3c_back
B 1E AF 0 spi_data_c5
B C5 AF 0 data_param_c5
L 0 010 0 xfer_c5_done
B 1F AF 0 get_spi_data_c5
B 00 C5 1 spi_data_c5_back
B 1D AF 0 spi_ctrl_desel
B 00 AF 1 ctrl_param_00
L 0 010 1 flash_deselected
B 7F AF 1 bad_opcode
L 8 010 1 error_led
B 0F AF 1 version_cmd_after_error
B 1B 03 1 version_after_error
B 00 0A 1 config_after_error
B 00 AF 1 cookie_after_error
L 8 010 1 error_still_lit

/* list.f */
source/link_pkg.sv
source/cmd_if.sv
source/flash_xfer_if.sv
source/esp_spi_slave.sv
source/cmd_parser.sv
source/ctrl_regs.sv
source/flash_spi_master.sv
source/esp_bridge_top.sv
verification/link_checker.sv
verification/esp_bridge_asserts.sv
verification/tb_esp_bridge.sv
